// ==== rtl/gc_pkg.sv ====
package gc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [23:0] offset_t;
  typedef logic [7:0]  region_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  opcode_t;
  typedef logic [2:0]  alu_op_t;

  localparam region_t REGION_CODE      = 8'h00;
  localparam region_t REGION_GARBLER   = 8'h01;
  localparam region_t REGION_EVALUATOR = 8'h02;
  localparam region_t REGION_OUT       = 8'h03;
  localparam region_t REGION_STACK     = 8'h04;

  localparam opcode_t ADD  = 4'h0;
  localparam opcode_t SUB  = 4'h1;
  localparam opcode_t AND  = 4'h2;
  localparam opcode_t OR   = 4'h3;
  localparam opcode_t XOR  = 4'h4;
  localparam opcode_t SHL  = 4'h5;
  localparam opcode_t SHR  = 4'h6;
  localparam opcode_t ADDI = 4'h7;
  localparam opcode_t LUI  = 4'h8;
  localparam opcode_t LDW  = 4'h9;
  localparam opcode_t STW  = 4'ha;
  localparam opcode_t STB  = 4'hb;
  localparam opcode_t BEQ  = 4'hc;
  localparam opcode_t BNE  = 4'hd;
  localparam opcode_t HALT = 4'he; // 4'hf executes as a no-op

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SHL = 3'd5;
  localparam alu_op_t ALU_SHR = 3'd6;

  typedef struct packed {
    addr_t      addr;
    word_t      wdata;
    logic       we;
    logic [3:0] be;
  } mem_req_t;

  typedef enum logic [1:0] {FETCH, EXEC, HALTED} core_state_t;

endpackage

// ==== rtl/gc_alu.sv ====
`timescale 1ns/1ps

module gc_alu (
  input  gc_pkg::alu_op_t i_op,
  input  gc_pkg::word_t   i_a,
  input  gc_pkg::word_t   i_b,
  output gc_pkg::word_t   o_result,
  output logic            o_equal
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0]; // Low 5 bits only

  always_comb begin
    case (i_op)
      gc_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      gc_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      gc_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      gc_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      gc_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      gc_pkg::ALU_SHL: begin
        o_result = i_a << shamt;
      end
      gc_pkg::ALU_SHR: begin
        o_result = i_a >> shamt; // Logical
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

  assign o_equal = (i_a == i_b); // Branch decision

endmodule

// ==== rtl/gc_regfile.sv ====
`timescale 1ns/1ps

module gc_regfile (
  input  logic             clk,
  input  logic             rst,
  input  gc_pkg::reg_idx_t i_rs1,
  input  gc_pkg::reg_idx_t i_rs2,
  input  gc_pkg::reg_idx_t i_rd,
  input  logic             i_we,
  input  gc_pkg::word_t    i_wdata,
  output gc_pkg::word_t    o_rs1_data,
  output gc_pkg::word_t    o_rs2_data
);

  gc_pkg::word_t regs [16];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin // r0 stays zero
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

// ==== rtl/gc_core.sv ====
`timescale 1ns/1ps

module gc_core (
  input  logic             clk,
  input  logic             rst,
  input  gc_pkg::word_t    i_rdata,
  output gc_pkg::mem_req_t o_req,
  output logic             o_terminate
);

  gc_pkg::core_state_t state_q;
  gc_pkg::addr_t       pc_q;
  gc_pkg::word_t       instr_q;

  gc_pkg::opcode_t  opcode;
  gc_pkg::reg_idx_t rd;
  gc_pkg::reg_idx_t rs1;
  gc_pkg::reg_idx_t rs2;
  gc_pkg::word_t    imm_sext;
  gc_pkg::word_t    imm_lui;

  gc_pkg::word_t   rs1_data;
  gc_pkg::word_t   rs2_data;
  gc_pkg::alu_op_t alu_op;
  gc_pkg::word_t   alu_a;
  gc_pkg::word_t   alu_b;
  gc_pkg::word_t   alu_result;
  logic            alu_equal;

  logic writes_rd;
  logic is_load;
  logic is_store;
  logic is_halt;
  logic take_branch;
  logic exec;
  logic rf_we;

  gc_pkg::word_t rf_wdata;
  gc_pkg::addr_t branch_target;

  assign opcode   = instr_q[31:28];
  assign rd       = instr_q[27:24];
  assign rs1      = instr_q[23:20];
  assign rs2      = instr_q[19:16];
  assign imm_sext = {{16{instr_q[15]}}, instr_q[15:0]};
  assign imm_lui  = {instr_q[15:0], 16'h0000};

  assign exec = (state_q == gc_pkg::EXEC);

  // Offset in words from the branch's own PC
  assign branch_target = pc_q + {imm_sext[29:0], 2'b00};

  always_comb begin
    alu_op      = gc_pkg::ALU_ADD;
    alu_a       = rs1_data;
    alu_b       = rs2_data;
    writes_rd   = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_halt     = 1'b0;
    take_branch = 1'b0;
    case (opcode)
      gc_pkg::ADD,
      gc_pkg::SUB,
      gc_pkg::AND,
      gc_pkg::OR,
      gc_pkg::XOR,
      gc_pkg::SHL,
      gc_pkg::SHR: begin
        alu_op    = gc_pkg::alu_op_t'(opcode[2:0]); // R-type codes match ALU select
        writes_rd = 1'b1;
      end
      gc_pkg::ADDI: begin
        alu_b     = imm_sext;
        writes_rd = 1'b1;
      end
      gc_pkg::LUI: begin
        alu_a     = '0;
        alu_b     = imm_lui;
        writes_rd = 1'b1;
      end
      gc_pkg::LDW: begin
        alu_b     = imm_sext; // Address = rs1 + imm
        is_load   = 1'b1;
        writes_rd = 1'b1;
      end
      gc_pkg::STW,
      gc_pkg::STB: begin
        alu_b    = imm_sext;
        is_store = 1'b1;
      end
      gc_pkg::BEQ: begin
        take_branch = alu_equal;
      end
      gc_pkg::BNE: begin
        take_branch = !alu_equal;
      end
      gc_pkg::HALT: begin
        is_halt = 1'b1;
      end
      default: begin
      end
    endcase
  end

  gc_regfile u_gc_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rf_we),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  gc_alu u_gc_alu (
    .i_op     (alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_equal  (alu_equal)
  );

  assign rf_we    = exec && writes_rd;
  assign rf_wdata = is_load ? i_rdata : alu_result;

  always_comb begin
    o_req.addr  = pc_q; // Fetch address by default
    o_req.wdata = rs2_data;
    o_req.we    = exec && is_store;
    o_req.be    = '0;
    if (exec && (is_load || is_store)) begin
      o_req.addr = alu_result;
    end
    if (is_store) begin
      o_req.be = (opcode == gc_pkg::STB) ? (4'b0001 << alu_result[1:0]) : 4'b1111;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= gc_pkg::FETCH;
      pc_q    <= '0;
    end else begin
      case (state_q)
        gc_pkg::FETCH: begin
          state_q <= gc_pkg::EXEC;
        end
        gc_pkg::EXEC: begin
          pc_q    <= take_branch ? branch_target : pc_q + 32'd4;
          state_q <= is_halt ? gc_pkg::HALTED : gc_pkg::FETCH;
        end
        default: begin
          state_q <= gc_pkg::HALTED; // Held until reset
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == gc_pkg::FETCH) begin
      instr_q <= i_rdata;
    end
  end

  assign o_terminate = (state_q == gc_pkg::HALTED);

endmodule

// ==== rtl/gc_mem_system.sv ====
`timescale 1ns/1ps

module gc_mem_system #(
  parameter int CODE_WORDS  = 64,
  parameter int G_WORDS     = 64,
  parameter int E_WORDS     = 64,
  parameter int OUT_WORDS   = 64,
  parameter int STACK_WORDS = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  gc_pkg::mem_req_t         i_req,
  input  logic [CODE_WORDS*32-1:0] i_p_init,
  input  logic [G_WORDS*32-1:0]    i_g_init,
  input  logic [E_WORDS*32-1:0]    i_e_init,
  output gc_pkg::word_t            o_rdata,
  output logic [OUT_WORDS*32-1:0]  o_out
);

  logic [7:0] code_mem  [4*CODE_WORDS];
  logic [7:0] g_mem     [4*G_WORDS];
  logic [7:0] e_mem     [4*E_WORDS];
  logic [7:0] out_mem   [4*OUT_WORDS];
  logic [7:0] stack_mem [4*STACK_WORDS];

  gc_pkg::region_t region;
  gc_pkg::offset_t offset;
  logic [31:0]     byte_idx;
  logic [3:0]      lane_we;

  gc_pkg::word_t code_rd;
  gc_pkg::word_t g_rd;
  gc_pkg::word_t e_rd;
  gc_pkg::word_t out_rd;
  gc_pkg::word_t stack_rd;

  assign region   = i_req.addr[31:24];
  assign offset   = i_req.addr[23:0];
  assign byte_idx = {8'h00, offset};

  // Bytes beyond the end of a region read as zero
  always_comb begin
    code_rd  = '0;
    g_rd     = '0;
    e_rd     = '0;
    out_rd   = '0;
    stack_rd = '0;
    for (int k = 0; k < 4; k++) begin
      if (byte_idx + k < 4*CODE_WORDS) code_rd[8*k +: 8] = code_mem[byte_idx + k];
      if (byte_idx + k < 4*G_WORDS) g_rd[8*k +: 8] = g_mem[byte_idx + k];
      if (byte_idx + k < 4*E_WORDS) e_rd[8*k +: 8] = e_mem[byte_idx + k];
      if (byte_idx + k < 4*OUT_WORDS) out_rd[8*k +: 8] = out_mem[byte_idx + k];
      if (byte_idx + k < 4*STACK_WORDS) stack_rd[8*k +: 8] = stack_mem[byte_idx + k];
    end
  end

  always_comb begin
    case (region)
      gc_pkg::REGION_CODE:      o_rdata = code_rd;
      gc_pkg::REGION_GARBLER:   o_rdata = g_rd;
      gc_pkg::REGION_EVALUATOR: o_rdata = e_rd;
      gc_pkg::REGION_OUT:       o_rdata = out_rd;
      gc_pkg::REGION_STACK:     o_rdata = stack_rd;
      default:                  o_rdata = '0; // Unmapped
    endcase
  end

  // Full word, or a single byte from wdata[7:0] at the offset
  always_comb begin
    lane_we = '0;
    if (i_req.we) begin
      case (i_req.be)
        4'b1111: lane_we = 4'b1111;
        4'b0001, 4'b0010, 4'b0100, 4'b1000: lane_we = 4'b0001;
        default: lane_we = '0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4*CODE_WORDS; i++) begin
        code_mem[i] <= i_p_init[8*i +: 8];
      end
      for (int i = 0; i < 4*G_WORDS; i++) begin
        g_mem[i] <= i_g_init[8*i +: 8];
      end
      for (int i = 0; i < 4*E_WORDS; i++) begin
        e_mem[i] <= i_e_init[8*i +: 8];
      end
      for (int i = 0; i < 4*OUT_WORDS; i++) begin
        out_mem[i] <= '0;
      end
      for (int i = 0; i < 4*STACK_WORDS; i++) begin
        stack_mem[i] <= '0;
      end
    end else begin
      // Garbler and evaluator are read-only
      for (int k = 0; k < 4; k++) begin
        if (lane_we[k]) begin
          if (region == gc_pkg::REGION_CODE && byte_idx + k < 4*CODE_WORDS) begin
            code_mem[byte_idx + k] <= i_req.wdata[8*k +: 8];
          end
          if (region == gc_pkg::REGION_OUT && byte_idx + k < 4*OUT_WORDS) begin
            out_mem[byte_idx + k] <= i_req.wdata[8*k +: 8];
          end
          if (region == gc_pkg::REGION_STACK && byte_idx + k < 4*STACK_WORDS) begin
            stack_mem[byte_idx + k] <= i_req.wdata[8*k +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4*OUT_WORDS; i++) begin
      o_out[8*i +: 8] = out_mem[i];
    end
  end

endmodule

// ==== rtl/gc_main.sv ====
`timescale 1ns/1ps

module gc_main #(
  parameter int CODE_WORDS  = 64,
  parameter int G_WORDS     = 64,
  parameter int E_WORDS     = 64,
  parameter int OUT_WORDS   = 64,
  parameter int STACK_WORDS = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [CODE_WORDS*32-1:0] i_p_init,
  input  logic [G_WORDS*32-1:0]    i_g_init,
  input  logic [E_WORDS*32-1:0]    i_e_init,
  output logic [OUT_WORDS*32-1:0]  o_out,
  output logic                     o_terminate
);

  gc_pkg::mem_req_t mem_req;
  gc_pkg::word_t    mem_rdata;

  gc_core u_gc_core (
    .clk         (clk),
    .rst         (rst),
    .i_rdata     (mem_rdata),
    .o_req       (mem_req),
    .o_terminate (o_terminate)
  );

  gc_mem_system #(
    .CODE_WORDS  (CODE_WORDS),
    .G_WORDS     (G_WORDS),
    .E_WORDS     (E_WORDS),
    .OUT_WORDS   (OUT_WORDS),
    .STACK_WORDS (STACK_WORDS)
  ) u_gc_mem_system (
    .clk      (clk),
    .rst      (rst),
    .i_req    (mem_req),
    .i_p_init (i_p_init),
    .i_g_init (i_g_init),
    .i_e_init (i_e_init),
    .o_rdata  (mem_rdata),
    .o_out    (o_out)
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

endmodule

// ==== verification/gc_main_chk.sv ====
`timescale 1ns/1ps

module gc_main_chk (
  input logic                clk,
  input logic                rst,
  input gc_pkg::core_state_t i_state,
  input gc_pkg::mem_req_t    i_req,
  input logic                i_terminate
);

  int fail_count = 0; // Read by the testbench at the end

  a_we_in_exec: assert property (@(posedge clk) disable iff (rst)
    i_req.we |-> (i_state == gc_pkg::EXEC))
  else begin
    $error("write enable high outside EXEC");
    fail_count++;
  end

  a_be_legal: assert property (@(posedge clk) disable iff (rst)
    i_req.we |-> ((i_req.be == 4'b1111) || $onehot(i_req.be)))
  else begin
    $error("byte enable %b is neither full word nor one-hot", i_req.be);
    fail_count++;
  end

  // Sticky until the next reset
  a_terminate_sticky: assert property (@(posedge clk) disable iff (rst)
    !$fell(i_terminate))
  else begin
    $error("terminate fell without a reset");
    fail_count++;
  end

endmodule

bind gc_core gc_main_chk u_gc_main_chk (
  .clk         (clk),
  .rst         (rst),
  .i_state     (state_q),
  .i_req       (o_req),
  .i_terminate (o_terminate)
);

// ==== verification/gc_main_tb.sv ====
`timescale 1ns/1ps

module gc_main_tb;

  localparam int WORDS      = 64;
  localparam int NUM_TESTS  = 6;
  localparam int REC_WORDS  = 64; // One stim record per test
  localparam int CODE_SLOTS = 32;
  localparam int IN_BASE    = 32; // Garbler words, then evaluator words
  localparam int EXP_BASE   = 40;
  localparam int N_IDX      = 48;
  localparam int HOLD_IDX   = 49;
  localparam int EXP_WORDS  = 8;

  logic                clk;
  logic                rst;
  logic [WORDS*32-1:0] p_init;
  logic [WORDS*32-1:0] g_init;
  logic [WORDS*32-1:0] e_init;
  logic [WORDS*32-1:0] out;
  logic                terminate;

  logic [31:0] stim [NUM_TESTS*REC_WORDS];
  string       test_names [NUM_TESTS];
  int          error_count;
  int          failed_tests;
  int          cycle_count;
  int          timeout_limit = 32'h7fff_ffff;

  tb_clk_gen #(.PERIOD_NS(10)) u_tb_clk_gen (.o_clk(clk));

  gc_main u_gc_main (
    .clk         (clk),
    .rst         (rst),
    .i_p_init    (p_init),
    .i_g_init    (g_init),
    .i_e_init    (e_init),
    .o_out       (out),
    .o_terminate (terminate)
  );

  task automatic check_word(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic load_and_reset(input int t);
    int base;
    base = t * REC_WORDS;
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < WORDS; i++) begin
      p_init[32*i +: 32] <= (i < CODE_SLOTS) ? stim[base + i] : 32'h0;
      g_init[32*i +: 32] <= (i < 4) ? stim[base + IN_BASE + i] : 32'h0;
      e_init[32*i +: 32] <= (i < 4) ? stim[base + IN_BASE + 4 + i] : 32'h0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Counts rising edges after the reset release edge
  task automatic wait_terminate(input int limit, output int cycles, output bit seen);
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < limit) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      seen = terminate;
    end
  endtask

  task automatic check_hold(input int cycles, input int base);
    logic [31:0] expected;
    repeat (cycles) begin
      @(negedge clk);
      for (int w = 0; w < WORDS; w++) begin
        expected = (w < EXP_WORDS) ? stim[base + EXP_BASE + w] : 32'h0; // Rest stays cleared
        check_word($sformatf("o_out[%0d]", w), out[32*w +: 32], expected);
      end
      if (!terminate) begin
        $display("terminate dropped while reset was low");
        error_count++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the run went past %0d clock cycles", timeout_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int base;
    int n;
    int hold;
    int cycles;
    bit seen;
    int errors_before;
    rst           = 1'b1;
    p_init        = '0;
    g_init        = '0;
    e_init        = '0;
    error_count   = 0;
    failed_tests  = 0;
    cycle_count   = 0;
    test_names[0] = "arithmetic and logic";
    test_names[1] = "input regions";
    test_names[2] = "stack and branches";
    test_names[3] = "byte stores";
    test_names[4] = "guarded regions";
    test_names[5] = "termination";
    for (int i = 0; i < NUM_TESTS * REC_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("verification/gc_main_stim.txt", stim);
    timeout_limit = 100;
    for (int t = 0; t < NUM_TESTS; t++) begin
      timeout_limit += 2 * int'(stim[t*REC_WORDS + N_IDX]) + 8;
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      errors_before = error_count;
      base = t * REC_WORDS;
      n    = int'(stim[base + N_IDX]);
      hold = int'(stim[base + HOLD_IDX]);
      load_and_reset(t);
      wait_terminate(2*n + 10, cycles, seen);
      if (!seen) begin
        $display("test %0d: terminate did not rise within %0d cycles of reset", t + 1,
                 2*n + 10);
        error_count++;
      end else if (cycles != 2*n) begin
        $display("test %0d: terminate rose %0d cycles after reset instead of %0d", t + 1,
                 cycles, 2*n);
        error_count++;
      end
      for (int w = 0; w < EXP_WORDS; w++) begin
        check_word($sformatf("o_out[%0d]", w), out[32*w +: 32], stim[base + EXP_BASE + w]);
      end
      if (hold > 0) begin
        check_hold(hold, base);
      end
      if (error_count == errors_before) begin
        $display("test %0d %s: passed", t + 1, test_names[t]);
      end else begin
        $display("test %0d %s: failed", t + 1, test_names[t]);
        failed_tests++;
      end
    end

    error_count += u_gc_main.u_gc_core.u_gc_main_chk.fail_count; // Assertion failures
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS,
             NUM_TESTS - failed_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verification/gc_main_stim.txt ====
// One 64-word record per test: code words at +00h, garbler 0..3 and evaluator 0..3 at +20h,
// expected out words 0..7 at +28h, instruction count N at +30h, hold cycles at +31h
// test 1 arithmetic and logic
@000 81000300 72001234 7300fff0 8400abcd 05240000 16230000 27530000 38320000 49530000 7a000024
5b5a0000 6c4a0000 a0130000 a0150004 a0160008 a017000c a0180010 a0190014 a01b0018 a01c001c
e0000000
@020 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@028 fffffff0 abcd1234 00001244 abcd1230 fffffff4 5432edc4 bcd12340 0abcd000 00000015 00000000
// test 2 input regions
@040 81000300 82000100 83000200 94200000 95300000 96200004 97300004 48450000 09450000 4a670000
0b670000 a0180000 a0190004 a01a0008 a01b000c e0000000
@060 13579bdf 0f0f0f0f 00000000 00000000 2468ace0 f0f0f0f3 00000000 00000000
@068 373f373f 37c048bf fffffffc 00000002 00000000 00000000 00000000 00000000 00000010 00000000
// test 3 stack and branches
@080 81000300 82000400 73000005 a0230000 72200004 7330ffff d030fffd 73000005 7220fffc 96200000
05560000 7330ffff d030fffc a0150000 97200010 a0170004 c0300002 a0110008 a012000c e0000000
@0a0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@0a8 0000000f 00000001 00000000 04000000 00000000 00000000 00000000 00000000 00000037 00000000
// test 4 byte stores
@0c0 81000300 72000011 73000022 74007f33 75000144 b0120000 b0130001 b0140002 b0150003 8600cafe
76600bad a0160004 77000055 b0170005 a0160008 b0120008 e0000000
@0e0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@0e8 44332211 cafe55ad cafe0b11 00000000 00000000 00000000 00000000 00000000 00000011 00000000
// test 5 guarded regions
@100 81000300 82000100 83000500 74005a5a a0240000 b0240004 a0340000 95200000 96200004 97300000
a0150000 a0160004 77700100 a0170008 89007800 79900777 a0090048 7a000002 78000001 a018000c
e0000000
@120 89abcdef 76543210 00000000 00000000 00000000 00000000 00000000 00000000
@128 89abcdef 76543210 00000100 00000777 00000000 00000000 00000000 00000000 00000015 00000000
// test 6 termination
@140 81000300 72000066 a0120000 e0000000 a0120004
@160 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
@168 00000066 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000004 00000014

// ==== compile.f ====
rtl/gc_pkg.sv
rtl/gc_alu.sv
rtl/gc_regfile.sv
rtl/gc_core.sv
rtl/gc_mem_system.sv
rtl/gc_main.sv
verification/tb_clk_gen.sv
verification/gc_main_chk.sv
verification/gc_main_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := gc_main_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
